// File: design/fetch_pkg.sv
// fetch types and codes for 32-bit rv32 words only; no compressed instructions, XLEN fixed at 32
package fetch_pkg;

   // address and instruction widths
   localparam int XLEN = 32;
   localparam int ILEN = 32; // memory word, one instruction per word

   // prediction code carried with each buffered instruction
   typedef enum logic [1:0] {
      PRED_NONE      = 2'b00, // plain instruction
      PRED_CALL      = 2'b01, // link address pushed on the stack
      PRED_RET       = 2'b10, // target popped from the stack
      PRED_RET_EMPTY = 2'b11  // return seen, stack was empty
   } pred_e;

   // j-type layout (jal)
   typedef struct packed {
      logic [19:0] imm;    // scrambled jump offset, not needed here
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } j_view_t;

   // i-type layout (jalr)
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_view_t;

   // same word, read as jal or as jalr by the predecoder
   typedef union packed {
      logic [ILEN-1:0] raw;
      j_view_t         j_view;
      i_view_t         i_view;
   } instr_u;

   // one buffer entry, prediction in the top two bits
   typedef struct packed {
      pred_e  pred;
      instr_u instr;
   } ifb_entry_t;

   // major opcodes of interest
   localparam logic [6:0] OPC_JAL  = 7'b1101111;
   localparam logic [6:0] OPC_JALR = 7'b1100111;

   // link registers per the calling convention hints
   localparam logic [4:0] REG_ZERO = 5'd0;
   localparam logic [4:0] REG_RA   = 5'd1; // x1
   localparam logic [4:0] REG_T0   = 5'd5; // x5, alternate link

endpackage

// File: design/ifb.sv
// shift buffer, IFB_SIZE >= 3; caller must never push into a full buffer without popping
module ifb #(
   parameter int IFB_SIZE = 4
) (
   input  logic                 s_clk_i,        // core clock
   input  logic                 s_resetn_i,     // sync, active low
   input  logic                 s_flush_i,      // drop all entries
   input  logic                 s_push_i,       // new word into entry 0
   input  logic                 s_pop_i,        // consume oldest entry
   input  fetch_pkg::pred_e     s_ras_pred_i,   // prediction for entry 0
   input  fetch_pkg::ifb_entry_t s_data_i,      // pushed entry
   output fetch_pkg::ifb_entry_t s_data_o,      // oldest entry
   output fetch_pkg::ifb_entry_t s_last_entry_o, // newest entry, raw
   output logic [IFB_SIZE-1:0]  s_occupied_o    // one bit per entry
);
   import fetch_pkg::*;

   ifb_entry_t          buf_q [IFB_SIZE]; // entry storage
   ifb_entry_t          buf_u [IFB_SIZE]; // storage with pred update applied
   logic [IFB_SIZE-1:0] occ_q;            // contiguous from bit 0
   logic [IFB_SIZE-1:0] occ_d;

   // ras may relabel the newest entry, older ones pass unchanged
   always_comb begin
      for (int i = 0; i < IFB_SIZE; i++) begin
         buf_u[i] = buf_q[i];
      end
      if (s_ras_pred_i != PRED_NONE) begin
         buf_u[0].pred = s_ras_pred_i; // in place, same cycle
      end
   end

   // data always enters at entry 0, older ones move up
   always_ff @(posedge s_clk_i) begin
      if (s_push_i) begin
         buf_q[0] <= s_data_i;
         for (int i = 1; i < IFB_SIZE; i++) begin
            buf_q[i] <= buf_u[i-1]; // carries the fresh prediction along
         end
      end else begin
         buf_q[0] <= buf_u[0]; // commit prediction of the newest entry
      end
   end

   // occupancy follows the shift direction
   always_comb begin
      occ_d = occ_q;
      if (s_flush_i) begin
         occ_d = '0;
      end else if (s_push_i && !s_pop_i) begin
         occ_d = {occ_q[IFB_SIZE-2:0], 1'b1}; // grow by one
      end else if (!s_push_i && s_pop_i) begin
         occ_d = {1'b0, occ_q[IFB_SIZE-1:1]}; // shrink by one
      end
      // push with pop keeps the count, the shift itself drops the oldest
   end

   always_ff @(posedge s_clk_i) begin
      if (!s_resetn_i) begin
         occ_q <= '0;
      end else begin
         occ_q <= occ_d;
      end
   end

   // oldest = highest occupied index, later iterations win
   always_comb begin
      s_data_o = buf_u[0];
      for (int i = 1; i < IFB_SIZE; i++) begin
         if (occ_q[i]) begin
            s_data_o = buf_u[i];
         end
      end
   end

   // raw newest entry for the predecoder, no loop through the update
   assign s_last_entry_o = buf_q[0];
   assign s_occupied_o   = occ_q;

endmodule

// File: design/ras.sv
// predecodes entry 0 only in the cycle after its push; full stack silently loses its oldest address
module ras #(
   parameter int RAS_DEPTH = 4
) (
   input  logic                      s_clk_i,         // core clock
   input  logic                      s_resetn_i,      // sync, active low
   input  logic                      s_flush_i,       // redirect, empty the stack
   input  logic                      s_push_i,        // ifb push strobe
   input  logic [fetch_pkg::XLEN-1:0] s_push_pc_i,    // address of the pushed word
   input  fetch_pkg::ifb_entry_t     s_last_entry_i,  // ifb entry 0
   output fetch_pkg::pred_e          s_pred_o,        // relabel for entry 0
   output logic [fetch_pkg::XLEN-1:0] s_target_o,     // predicted return address
   output logic                      s_target_valid_o // one-cycle strobe
);
   import fetch_pkg::*;

   localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
   localparam int CNT_W = $clog2(RAS_DEPTH + 1);

   logic [XLEN-1:0]  stk_q [RAS_DEPTH]; // circular link address store
   logic [PTR_W-1:0] ptr_q;             // next free slot
   logic [PTR_W-1:0] ptr_inc;
   logic [PTR_W-1:0] ptr_dec;           // slot of the top entry
   logic [CNT_W-1:0] cnt_q;             // valid entries, saturates
   logic             pend_q;            // entry 0 not yet decoded
   logic [XLEN-1:0]  pc_q;              // pc of entry 0
   instr_u           ins;
   logic             is_call;
   logic             is_ret;
   logic             stk_empty;

   assign ins = s_last_entry_i.instr;

   // jal with a link rd
   assign is_call = pend_q && !s_flush_i
                    && (ins.j_view.opcode == OPC_JAL)
                    && ((ins.j_view.rd == REG_RA) || (ins.j_view.rd == REG_T0));

   // jalr x0, 0(link)
   assign is_ret = pend_q && !s_flush_i
                   && (ins.i_view.opcode == OPC_JALR)
                   && (ins.i_view.rd == REG_ZERO)
                   && ((ins.i_view.rs1 == REG_RA) || (ins.i_view.rs1 == REG_T0));

   assign stk_empty = (cnt_q == '0);

   // modulo RAS_DEPTH pointer arithmetic
   assign ptr_inc = (ptr_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
   assign ptr_dec = (ptr_q == '0) ? PTR_W'(RAS_DEPTH - 1) : ptr_q - 1'b1;

   always_comb begin
      s_pred_o = PRED_NONE;
      if (is_call) begin
         s_pred_o = PRED_CALL;
      end else if (is_ret) begin
         s_pred_o = stk_empty ? PRED_RET_EMPTY : PRED_RET;
      end
   end

   assign s_target_o       = stk_q[ptr_dec];      // top of stack
   assign s_target_valid_o = is_ret && !stk_empty; // only on a real pop

   // control state
   always_ff @(posedge s_clk_i) begin
      if (!s_resetn_i || s_flush_i) begin
         pend_q <= 1'b0;
         ptr_q  <= '0;
         cnt_q  <= '0;
      end else begin
         pend_q <= s_push_i; // decode exactly once per push
         if (is_call) begin
            ptr_q <= ptr_inc;
            if (cnt_q != CNT_W'(RAS_DEPTH)) begin
               cnt_q <= cnt_q + 1'b1;
            end // else oldest slot gets overwritten
         end else if (is_ret && !stk_empty) begin
            ptr_q <= ptr_dec;
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   // link address = call pc + 4
   always_ff @(posedge s_clk_i) begin
      if (is_call) begin
         stk_q[ptr_q] <= pc_q + XLEN'(4);
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (s_push_i) begin
         pc_q <= s_push_pc_i;
      end
   end

endmodule

// File: design/fetch_ctrl.sv
// sequential fetch, memory must answer exactly one cycle after each request with no stall
module fetch_ctrl #(
   parameter int IFB_SIZE = 4
) (
   input  logic                       s_clk_i,         // core clock
   input  logic                       s_resetn_i,      // sync, active low
   input  logic                       s_redirect_i,    // restart fetch
   input  logic [fetch_pkg::XLEN-1:0] s_redirect_pc_i, // new fetch address
   input  logic [IFB_SIZE-1:0]        s_occupied_i,    // ifb occupancy
   input  logic                       s_pop_i,         // decode takes an entry
   output logic                       s_imem_req_o,    // read strobe
   output logic [fetch_pkg::XLEN-1:0] s_imem_addr_o,   // read address
   input  logic [fetch_pkg::ILEN-1:0] s_imem_rdata_i,  // word, one cycle later
   output logic                       s_push_o,        // ifb push
   output fetch_pkg::ifb_entry_t      s_push_data_o,   // entry to push
   output logic [fetch_pkg::XLEN-1:0] s_push_pc_o      // pc of pushed word
);
   import fetch_pkg::*;

   localparam int CNT_W = $clog2(IFB_SIZE + 2);

   logic [XLEN-1:0]  pc_q;        // next fetch address
   logic             run_q;       // low until first cycle out of reset
   logic             infl_q;      // response due this cycle
   logic [XLEN-1:0]  infl_addr_q; // its address
   logic [CNT_W-1:0] occ_cnt;     // occupied + in flight
   logic             room;

   // occupied entries plus the outstanding word
   always_comb begin
      occ_cnt = CNT_W'(infl_q);
      for (int i = 0; i < IFB_SIZE; i++) begin
         occ_cnt = occ_cnt + CNT_W'(s_occupied_i[i]);
      end
   end

   // a pop this cycle frees one slot before our word lands
   assign room = occ_cnt < (CNT_W'(IFB_SIZE) + CNT_W'(s_pop_i));

   assign s_imem_req_o  = run_q && !s_redirect_i && room;
   assign s_imem_addr_o = pc_q;

   // response becomes a push, unless redirect drops it
   assign s_push_o    = infl_q && !s_redirect_i;
   assign s_push_pc_o = infl_addr_q;

   always_comb begin
      s_push_data_o.pred      = PRED_NONE; // ras fills this in later
      s_push_data_o.instr.raw = s_imem_rdata_i;
   end

   always_ff @(posedge s_clk_i) begin
      if (!s_resetn_i) begin
         run_q  <= 1'b0;
         infl_q <= 1'b0;
         pc_q   <= '0;
      end else begin
         run_q  <= 1'b1;
         infl_q <= s_imem_req_o; // never set in a redirect cycle
         if (s_redirect_i) begin
            pc_q <= s_redirect_pc_i;
         end else if (s_imem_req_o) begin
            pc_q <= pc_q + XLEN'(4); // next word
         end
      end
   end

   // address travels with the request
   always_ff @(posedge s_clk_i) begin
      if (s_imem_req_o) begin
         infl_addr_q <= pc_q;
      end
   end

endmodule

// File: design/fetch_top.sv
// fetch front end top; pop only while s_valid_o is high, IFB_SIZE >= 3
module fetch_top #(
   parameter int IFB_SIZE  = 4,
   parameter int RAS_DEPTH = 4
) (
   input  logic                       s_clk_i,              // core clock
   input  logic                       s_resetn_i,           // sync, active low
   input  logic                       s_redirect_i,         // flush and restart
   input  logic [fetch_pkg::XLEN-1:0] s_redirect_pc_i,      // restart address
   input  logic                       s_pop_i,              // decode pop
   output logic                       s_imem_req_o,         // memory read strobe
   output logic [fetch_pkg::XLEN-1:0] s_imem_addr_o,        // memory address
   input  logic [fetch_pkg::ILEN-1:0] s_imem_rdata_i,       // memory data, 1 cycle later
   output logic                       s_valid_o,            // buffer not empty
   output fetch_pkg::ifb_entry_t      s_entry_o,            // oldest entry
   output logic [fetch_pkg::XLEN-1:0] s_ras_target_o,       // predicted return target
   output logic                       s_ras_target_valid_o  // target strobe
);
   import fetch_pkg::*;

   logic [IFB_SIZE-1:0] occupied;
   logic                push;
   ifb_entry_t          push_data;
   logic [XLEN-1:0]     push_pc;
   ifb_entry_t          last_entry; // ifb entry 0 to predecoder
   pred_e               ras_pred;   // predecoder result back to ifb

   assign s_valid_o = |occupied;

   fetch_ctrl #(
      .IFB_SIZE (IFB_SIZE)
   ) u_fetch_ctrl (
      .s_clk_i         (s_clk_i),
      .s_resetn_i      (s_resetn_i),
      .s_redirect_i    (s_redirect_i),
      .s_redirect_pc_i (s_redirect_pc_i),
      .s_occupied_i    (occupied),
      .s_pop_i         (s_pop_i),
      .s_imem_req_o    (s_imem_req_o),
      .s_imem_addr_o   (s_imem_addr_o),
      .s_imem_rdata_i  (s_imem_rdata_i),
      .s_push_o        (push),
      .s_push_data_o   (push_data),
      .s_push_pc_o     (push_pc)
   );

   ifb #(
      .IFB_SIZE (IFB_SIZE)
   ) u_ifb (
      .s_clk_i        (s_clk_i),
      .s_resetn_i     (s_resetn_i),
      .s_flush_i      (s_redirect_i),
      .s_push_i       (push),
      .s_pop_i        (s_pop_i),
      .s_ras_pred_i   (ras_pred),
      .s_data_i       (push_data),
      .s_data_o       (s_entry_o),
      .s_last_entry_o (last_entry),
      .s_occupied_o   (occupied)
   );

   ras #(
      .RAS_DEPTH (RAS_DEPTH)
   ) u_ras (
      .s_clk_i          (s_clk_i),
      .s_resetn_i       (s_resetn_i),
      .s_flush_i        (s_redirect_i),
      .s_push_i         (push),
      .s_push_pc_i      (push_pc),
      .s_last_entry_i   (last_entry),
      .s_pred_o         (ras_pred),
      .s_target_o       (s_ras_target_o),
      .s_target_valid_o (s_ras_target_valid_o)
   );

endmodule

// File: verif/fetch_chk.sv
// bound into fetch_top; holds only for a memory that answers every request one cycle later
module fetch_chk #(
   parameter int IFB_SIZE = 4
) (
   input logic                  clk_i,
   input logic                  resetn_i,
   input logic                  flush_i,        // redirect
   input logic                  push_i,         // ifb push strobe
   input logic [IFB_SIZE-1:0]   occupied_i,
   input fetch_pkg::pred_e      ras_pred_i,     // ras relabel of entry 0
   input logic                  target_valid_i
);
   timeunit 1ns;
   timeprecision 1ps;
   import fetch_pkg::*;

   int chk_errs = 0; // read by the testbench top

   // occupancy must look like 0..01..1
   occ_contig: assert property (@(posedge clk_i) disable iff (!resetn_i)
      (occupied_i & (occupied_i + 1'b1)) == '0)
      else begin
         chk_errs++;
         $error("occupancy bits not contiguous from bit 0");
      end

   no_push_full: assert property (@(posedge clk_i) disable iff (!resetn_i)
      (&occupied_i) |-> !push_i)
      else begin
         chk_errs++;
         $error("push into a full buffer");
      end

   no_pred_flush: assert property (@(posedge clk_i) disable iff (!resetn_i)
      flush_i |-> (ras_pred_i == PRED_NONE))
      else begin
         chk_errs++;
         $error("prediction during a flush cycle");
      end

   // each strobe belongs to the decode cycle right after one push
   tgt_one_cycle: assert property (@(posedge clk_i) disable iff (!resetn_i)
      target_valid_i |-> $past(push_i))
      else begin
         chk_errs++;
         $error("target strobe not tied to a single push");
      end

endmodule

bind fetch_top fetch_chk #(
   .IFB_SIZE (IFB_SIZE)
) u_fetch_chk (
   .clk_i          (s_clk_i),
   .resetn_i       (s_resetn_i),
   .flush_i        (s_redirect_i),
   .push_i         (push),
   .occupied_i     (occupied),
   .ras_pred_i     (ras_pred),
   .target_valid_i (s_ras_target_valid_o)
);

// File: verif/mem_image.svh
// instruction image, a pure function of the whole address; calls link x1 or x5, returns use jalr x0

function automatic logic [31:0] mem_word(input logic [31:0] addr);
   logic [7:0]  h;
   logic [5:0]  idx;
   logic [11:0] imm;
   h   = (addr[9:2] * 8'd37) ^ addr[17:10] ^ addr[25:18] ^ {2'b00, addr[31:26]}; // scatter kinds
   idx = addr[7:2];                                       // word index inside a region
   imm = addr[13:2] ^ addr[25:14] ^ {6'h00, addr[31:26]}; // every address bit reaches the word
   if (addr[31:12] == 20'h00001) begin
      // six nested calls, then seven returns
      if (idx < 6) begin
         return {20'h00000, (idx[0] ? 5'd5 : 5'd1), 7'b1101111}; // jal x1 / jal x5
      end else if (idx < 13) begin
         return {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};       // jalr x0, 0(x1)
      end
   end else if (addr[31:12] == 20'h00003) begin
      // short nested pair
      case (idx)
         6'd0, 6'd4: return {20'h00000, 5'd1, 7'b1101111};
         6'd3:       return {20'h00000, 5'd5, 7'b1101111};
         6'd2, 6'd5: return {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};
         6'd6:       return {12'h000, 5'd5, 3'b000, 5'd0, 7'b1100111};
         default:    ;
      endcase
   end else begin
      case (h[2:0])
         3'd0:       return {20'h00000, 5'd1, 7'b1101111};
         3'd1:       return {20'h00000, 5'd5, 7'b1101111};
         3'd2, 3'd3: return {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};
         default:    ;
      endcase
   end
   return {imm, 5'd2, 3'b000, 5'd3, 7'b0010011}; // addi x3, x2, imm
endfunction

// File: verif/fetch_scoreboard.sv
// reference model stepped in pop order; assumes the bench pops only while s_valid_o is high
module fetch_scoreboard #(
   parameter int IFB_SIZE  = 4,
   parameter int RAS_DEPTH = 4
) (
   input  logic                       s_clk_i,
   input  logic                       s_resetn_i,
   input  logic                       s_redirect_i,
   input  logic [fetch_pkg::XLEN-1:0] s_redirect_pc_i,
   input  logic                       s_pop_i,
   input  logic                       imem_req_i,
   input  logic                       valid_i,
   input  fetch_pkg::ifb_entry_t      entry_i,
   input  logic [fetch_pkg::XLEN-1:0] target_i,
   input  logic                       target_valid_i,
   input  logic                       test_end_i,   // one-cycle strobe per finished test
   input  logic [7:0]                 test_num_i,
   input  logic                       final_i,      // end of run
   output int                         err_cnt_o,
   output int                         chk_cnt_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import fetch_pkg::*;
`include "mem_image.svh"

   logic [31:0] model_pc;
   logic [31:0] model_stk[$];  // back = top, front = oldest
   logic [31:0] tgt_q[$];      // strobed targets not yet matched
   int          outstanding;   // requests minus pops since flush
   int          test_pops;
   int          test_errs;
   int          n_call;
   int          n_ret;
   int          n_empty;

   initial begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
      test_pops = 0;
      test_errs = 0;
      n_call    = 0;
      n_ret     = 0;
      n_empty   = 0;
   end

   task automatic report_fail(input string msg);
      $display("Fail %0t: %s", $time, msg);
      err_cnt_o++;
      test_errs++;
   endtask

   // one model step: expected word, label and target of the next popped entry
   function automatic void ref_step(output logic [31:0] exp_word, output pred_e exp_pred,
                                    output logic [31:0] exp_tgt);
      logic [31:0] w;
      w        = mem_word(model_pc);
      exp_word = w;
      exp_pred = PRED_NONE;
      exp_tgt  = '0;
      if (w[6:0] == OPC_JAL && (w[11:7] == 5'd1 || w[11:7] == 5'd5)) begin
         exp_pred = PRED_CALL;
         model_stk.push_back(model_pc + 32'd4);
         if (model_stk.size() > RAS_DEPTH) void'(model_stk.pop_front()); // oldest lost
      end else if (w[6:0] == OPC_JALR && w[11:7] == 5'd0
                   && (w[19:15] == 5'd1 || w[19:15] == 5'd5)) begin
         if (model_stk.size() == 0) begin
            exp_pred = PRED_RET_EMPTY;
         end else begin
            exp_pred = PRED_RET;
            exp_tgt  = model_stk.pop_back();
         end
      end
      model_pc = model_pc + 32'd4;
   endfunction

   always @(posedge s_clk_i) begin
      logic [31:0] ew;
      logic [31:0] et;
      logic [31:0] got;
      pred_e       ep;
      if (!s_resetn_i || s_redirect_i) begin
         model_pc    = s_resetn_i ? s_redirect_pc_i : '0; // restart point
         model_stk.delete();
         tgt_q.delete();
         outstanding = 0;
      end else begin
         if (target_valid_i) tgt_q.push_back(target_i); // before a same-cycle pop
         outstanding = outstanding + int'(imem_req_i) - int'(s_pop_i);
         if (outstanding > IFB_SIZE) begin
            report_fail($sformatf("%0d words outstanding, buffer holds %0d",
                                  outstanding, IFB_SIZE));
         end
         if (s_pop_i) begin
            ref_step(ew, ep, et);
            chk_cnt_o++;
            test_pops++;
            if (!valid_i) report_fail("pop while buffer empty");
            if (entry_i.instr.raw !== ew) begin
               report_fail($sformatf("word %h, expected %h at pc %h",
                                     entry_i.instr.raw, ew, model_pc - 32'd4));
            end
            if (entry_i.pred !== ep) begin
               report_fail($sformatf("pred %s, expected %s at pc %h",
                                     entry_i.pred.name(), ep.name(), model_pc - 32'd4));
            end
            case (ep)
               PRED_CALL:      n_call++;
               PRED_RET_EMPTY: n_empty++;
               default:        ;
            endcase
            if (ep == PRED_RET) begin
               n_ret++;
               if (tgt_q.size() == 0) begin
                  report_fail("return popped without a target strobe");
               end else begin
                  got = tgt_q.pop_front();
                  if (got !== et) report_fail($sformatf("target %h, expected %h", got, et));
               end
            end
         end
      end
      if (test_end_i) begin
         $display("test %0d %s: %0d pops, %0d errors", test_num_i,
                  (test_errs == 0 && test_pops > 0) ? "ok" : "bad", test_pops, test_errs);
         if (test_pops == 0) begin
            $display("test %0d popped nothing", test_num_i);
            err_cnt_o++;
         end
         test_pops = 0;
         test_errs = 0;
      end
      if (final_i && (n_call == 0 || n_ret == 0 || n_empty == 0)) begin
         $display("some prediction kind was never popped: calls %0d rets %0d empty %0d",
                  n_call, n_ret, n_empty);
         err_cnt_o++;
      end
   end

endmodule

// File: verif/tb_fetch.sv
// fetch front end bench; ideal one-cycle memory, pops at most every other cycle
module tb_fetch;
   timeunit 1ns;
   timeprecision 1ps;
   import fetch_pkg::*;
`include "mem_image.svh"

   localparam int IFB_SIZE     = 4;
   localparam int RAS_DEPTH    = 4;
   localparam int RESET_CYCLES = 10;
   localparam int TEST_CYCLES  = 300 + 400 + 120 + 160 + 40 + 2 + 240 + 5 * 2 + 5 + 3;
   localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * 100 + 5000; // plus margin

   localparam int POP_STEADY = 0;
   localparam int POP_BURSTY = 1; // long pauses
   localparam int POP_NONE   = 2;

   logic            clk = 1'b0;
   logic            resetn;
   logic            redirect;
   logic [XLEN-1:0] redirect_pc;
   logic            pop;
   logic [31:0]     rdata;
   logic            imem_req;
   logic [XLEN-1:0] imem_addr;
   logic            valid;
   ifb_entry_t      entry;
   logic [XLEN-1:0] ras_target;
   logic            ras_target_valid;
   logic            test_end;
   logic [7:0]      test_num;
   logic            final_flag;
   int              err_cnt;
   int              chk_cnt;
   int              total_errs;
   integer          seed = 53;

   always #50 clk = ~clk;

   fetch_top #(
      .IFB_SIZE  (IFB_SIZE),
      .RAS_DEPTH (RAS_DEPTH)
   ) u_fetch_top (
      .s_clk_i              (clk),
      .s_resetn_i           (resetn),
      .s_redirect_i         (redirect),
      .s_redirect_pc_i      (redirect_pc),
      .s_pop_i              (pop),
      .s_imem_req_o         (imem_req),
      .s_imem_addr_o        (imem_addr),
      .s_imem_rdata_i       (rdata),
      .s_valid_o            (valid),
      .s_entry_o            (entry),
      .s_ras_target_o       (ras_target),
      .s_ras_target_valid_o (ras_target_valid)
   );

   fetch_scoreboard #(
      .IFB_SIZE  (IFB_SIZE),
      .RAS_DEPTH (RAS_DEPTH)
   ) u_scoreboard (
      .s_clk_i (clk), .s_resetn_i (resetn), .s_redirect_i (redirect),
      .s_redirect_pc_i (redirect_pc), .s_pop_i (pop), .imem_req_i (imem_req),
      .valid_i (valid), .entry_i (entry), .target_i (ras_target),
      .target_valid_i (ras_target_valid), .test_end_i (test_end), .test_num_i (test_num),
      .final_i (final_flag), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
   );

   // memory answers the cycle after each request
   always @(posedge clk) begin
      if (imem_req) rdata <= mem_word(imem_addr);
   end

   function automatic logic pop_wanted(input int mode, input int i, input int r);
      case (mode)
         POP_STEADY: return r[1:0] != 2'b00;
         POP_BURSTY: return (i % 100) >= 60; // 60 idle, 40 busy
         default:    return 1'b0;
      endcase
   endfunction

   // valid sampled before the edge still holds if nothing was popped or flushed
   task automatic step_cycles(input int n, input int mode);
      int r;
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         r = $random(seed);
         redirect <= 1'b0;
         pop      <= !pop && !redirect && valid && pop_wanted(mode, i, r);
      end
   endtask

   task automatic redirect_to(input logic [XLEN-1:0] addr);
      @(posedge clk);
      redirect    <= 1'b1;
      redirect_pc <= addr;
      pop         <= 1'b0;
   endtask

   task automatic end_test(input int num);
      @(posedge clk);
      test_end <= 1'b1;
      test_num <= 8'(num);
      redirect <= 1'b0;
      pop      <= 1'b0;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   initial begin
      resetn      = 1'b0;
      redirect    = 1'b0;
      redirect_pc = '0;
      pop         = 1'b0;
      rdata       = '0;
      test_end    = 1'b0;
      test_num    = '0;
      final_flag  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      resetn <= 1'b1;
      step_cycles(300, POP_STEADY); // sequential stream from zero
      end_test(1);
      step_cycles(400, POP_BURSTY); // fill, stall, resume
      end_test(2);
      redirect_to(32'h0000_3000);   // short nested call and return
      step_cycles(120, POP_STEADY);
      end_test(3);
      redirect_to(32'h0000_1000);   // deeper than the stack
      step_cycles(160, POP_STEADY);
      end_test(4);
      step_cycles(40, POP_NONE);    // full buffer, then throw it away
      redirect_to(32'h0000_1000);   // jal x1 lands, still undecoded
      step_cycles(2, POP_NONE);
      redirect_to(32'h0000_2000);   // flush hits its decode cycle
      step_cycles(240, POP_STEADY);
      end_test(5);
      final_flag <= 1'b1;
      @(posedge clk);
      final_flag <= 1'b0;
      @(posedge clk);
      total_errs = err_cnt + u_fetch_top.u_fetch_chk.chk_errs;
      $display("pops checked %0d, errors %0d, assertion failures %0d",
               chk_cnt, err_cnt, u_fetch_top.u_fetch_chk.chk_errs);
      if (total_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS * 1ns);
      $display("watchdog expired after %0d ns, run did not complete", TIMEOUT_NS);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: src.f
+incdir+verif
design/fetch_pkg.sv
design/ifb.sv
design/ras.sv
design/fetch_ctrl.sv
design/fetch_top.sv
verif/fetch_chk.sv
verif/fetch_scoreboard.sv
verif/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - design/fetch_pkg.sv
      - design/ifb.sv
      - design/ras.sv
      - design/fetch_ctrl.sv
      - design/fetch_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fetch_chk.sv
      - verif/fetch_scoreboard.sv
      - verif/tb_fetch.sv
